// File: Makefile
SIM := obj_dir/Vtb_mbox_top

all: run

$(SIM): vlog.f $(shell cat vlog.f)
	verilator --binary --timing --assert --top-module tb_mbox_top -f vlog.f -o Vtb_mbox_top

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: boot_fsm.sv
// Boot sequencer that takes the fuse key, gates mailbox execution and flags misuse of the flow
`timescale 1ns/1ps
`default_nettype none

module boot_fsm import mbox_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              fuse_key_we,
    input  logic              fuse_done_we,
    input  logic              execute_we,
    input  logic [data_w-1:0] wdata,
    input  logic [6:0]        dlen,
    input  logic              eng_done,
    output logic [data_w-1:0] fuse_key,
    output logic              exec_start,
    output boot_state_t       state,
    output logic              ready_for_fuses,
    output logic              ready_for_mb_processing,
    output logic              mailbox_data_avail,
    output logic              err_fatal_set,
    output logic              err_nf_set
);

    logic dlen_bad;
    logic exec_ok;

    assign dlen_bad = dlen > 7'(mbox_depth);
    assign exec_ok  = execute_we && (state == boot_ready) && !dlen_bad;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= boot_fuses;
        end else begin
            case (state)
                boot_fuses: begin
                    if (fuse_done_we) begin
                        state <= boot_ready;
                    end
                end
                boot_ready: begin
                    if (execute_we && dlen_bad) begin
                        state <= boot_error;
                    end else if (exec_ok) begin
                        state <= boot_busy;
                    end
                end
                boot_busy: begin
                    if (eng_done) begin
                        state <= boot_ready;
                    end
                end
                // Error is terminal until reset
                default: begin
                    state <= boot_error;
                end
            endcase
        end
    end

    // Key is only accepted while fuses are open
    always_ff @(posedge clk) begin
        if (fuse_key_we && (state == boot_fuses)) begin
            fuse_key <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_start         <= 1'b0;
            mailbox_data_avail <= 1'b0;
        end else begin
            exec_start <= exec_ok;
            if (exec_ok) begin
                mailbox_data_avail <= 1'b0;
            end else if ((state == boot_busy) && eng_done) begin
                mailbox_data_avail <= 1'b1;
            end
        end
    end

    assign ready_for_fuses         = (state == boot_fuses);
    assign ready_for_mb_processing = (state == boot_ready) || (state == boot_busy);

    // Rule breaks, one pulse per offending write
    assign err_fatal_set = execute_we && (state == boot_ready) && dlen_bad;
    assign err_nf_set    = ((fuse_key_we || fuse_done_we) && (state != boot_fuses)) ||
                           (execute_we && ((state == boot_fuses) || (state == boot_busy)));

endmodule

`default_nettype wire

// File: digest_engine.sv
// Digest engine that reads the mailbox in order and folds each word into a key-seeded accumulator
`timescale 1ns/1ps
`default_nettype none

module digest_engine import mbox_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   exec_start,
    input  logic [data_w-1:0]      seed,
    input  logic [6:0]             dlen,
    input  logic                   rd_grant,
    input  logic [data_w-1:0]      rd_data,
    output logic                   rd_req,
    output logic [mbox_addr_w-1:0] rd_addr,
    output logic [data_w-1:0]      digest,
    output logic                   done
);

    logic              active;
    logic [6:0]        len;
    logic [6:0]        issue_cnt;
    logic [6:0]        fold_cnt;
    logic              rd_fire;
    logic              rd_vld;
    logic [data_w-1:0] acc;

    // One read per cycle until every word has been requested
    assign rd_req  = active && (issue_cnt < len);
    assign rd_fire = rd_req && rd_grant;
    assign rd_addr = issue_cnt[mbox_addr_w-1:0];
    assign digest  = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            issue_cnt <= '0;
            fold_cnt  <= '0;
            rd_vld    <= 1'b0;
            done      <= 1'b0;
        end else begin
            done   <= 1'b0;
            rd_vld <= rd_fire;
            if (exec_start) begin
                active    <= 1'b1;
                issue_cnt <= '0;
                fold_cnt  <= '0;
            end else if (active) begin
                if (rd_fire) begin
                    issue_cnt <= issue_cnt + 7'd1;
                end
                if (rd_vld) begin
                    fold_cnt <= fold_cnt + 7'd1;
                end
                // All words folded, a zero length finishes at once
                if (fold_cnt == len) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // Read data arrives in issue order, one cycle after the grant
    always_ff @(posedge clk) begin
        if (exec_start) begin
            acc <= seed;
            len <= dlen;
        end else if (rd_vld) begin
            acc <= {acc[data_w-2:0], acc[data_w-1]} ^ rd_data;
        end
    end

endmodule

`default_nettype wire

// File: mbox_ctrl.sv
// SoC register decode, mailbox SRAM sharing between SoC and digest engine, and sticky error flags
`timescale 1ns/1ps
`default_nettype none

module mbox_ctrl import mbox_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // SoC port
    input  logic                   soc_req,
    input  logic                   soc_we,
    input  logic [soc_addr_w-1:0]  soc_addr,
    input  logic [data_w-1:0]      soc_wdata,
    output logic                   soc_rvalid,
    output logic [data_w-1:0]      soc_rdata,
    // Sequencer and engine status
    input  boot_state_t            state,
    input  logic [data_w-1:0]      digest,
    input  logic                   mailbox_data_avail,
    input  logic                   err_fatal_set,
    input  logic                   err_nf_set,
    // Engine read port
    input  logic                   eng_rd_req,
    input  logic [mbox_addr_w-1:0] eng_rd_addr,
    output logic                   eng_rd_grant,
    output logic [data_w-1:0]      eng_rd_data,
    // Register strobes towards the sequencer
    output logic                   fuse_key_we,
    output logic                   fuse_done_we,
    output logic                   execute_we,
    output logic [data_w-1:0]      wdata,
    output logic [6:0]             dlen,
    // Exported mailbox SRAM
    output logic                   mbox_sram_cs,
    output logic                   mbox_sram_we,
    output logic [mbox_addr_w-1:0] mbox_sram_addr,
    output logic [data_w-1:0]      mbox_sram_wdata,
    input  logic [data_w-1:0]      mbox_sram_rdata,
    output logic                   cptra_error_fatal,
    output logic                   cptra_error_non_fatal
);

    logic              busy;
    logic              is_mbox;
    logic              soc_mbox_rd;
    logic              soc_mbox_wr;
    logic              soc_wr_drop;
    logic              soc_sram_sel;
    logic [data_w-1:0] status_word;
    logic [data_w-1:0] reg_rdata;
    logic              rd_p1;
    logic              mbox_rd_p1;
    logic [data_w-1:0] reg_rdata_p1;

    assign busy    = (state == boot_busy);
    assign is_mbox = (soc_addr[soc_addr_w-1:mbox_addr_w] ==
                      reg_mbox_base[soc_addr_w-1:mbox_addr_w]);

    // Mailbox writes are lost while the engine owns the contents
    assign soc_mbox_rd  = soc_req && !soc_we && is_mbox;
    assign soc_mbox_wr  = soc_req && soc_we && is_mbox && !busy;
    assign soc_wr_drop  = soc_req && soc_we && is_mbox && busy;
    assign soc_sram_sel = soc_mbox_rd || soc_mbox_wr;

    // SoC wins the SRAM, engine retries next cycle
    assign eng_rd_grant    = eng_rd_req && !soc_sram_sel;
    assign eng_rd_data     = mbox_sram_rdata;
    assign mbox_sram_cs    = soc_sram_sel || eng_rd_grant;
    assign mbox_sram_we    = soc_mbox_wr;
    assign mbox_sram_addr  = soc_sram_sel ? soc_addr[mbox_addr_w-1:0] : eng_rd_addr;
    assign mbox_sram_wdata = soc_wdata;

    assign fuse_key_we  = soc_req && soc_we && (soc_addr == reg_fuse_key);
    assign fuse_done_we = soc_req && soc_we && (soc_addr == reg_fuse_done);
    assign execute_we   = soc_req && soc_we && (soc_addr == reg_execute);
    assign wdata        = soc_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            dlen <= '0;
        end else if (soc_req && soc_we && (soc_addr == reg_dlen)) begin
            dlen <= soc_wdata[6:0];
        end
    end

    always_comb begin
        status_word                    = '0;
        status_word[status_busy]       = busy;
        status_word[status_data_avail] = mailbox_data_avail;
        status_word[status_err_nf]     = cptra_error_non_fatal;
        status_word[status_err_fatal]  = cptra_error_fatal;
    end

    // Key and execute read as zero
    always_comb begin
        case (soc_addr)
            reg_fuse_done: reg_rdata = {{(data_w-1){1'b0}}, state != boot_fuses};
            reg_dlen:      reg_rdata = {{(data_w-7){1'b0}}, dlen};
            reg_result:    reg_rdata = digest;
            reg_status:    reg_rdata = status_word;
            default:       reg_rdata = '0;
        endcase
    end

    // Two-stage read return, matches the SRAM latency plus one output register
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_p1      <= 1'b0;
            soc_rvalid <= 1'b0;
        end else begin
            rd_p1      <= soc_req && !soc_we;
            soc_rvalid <= rd_p1;
        end
    end

    always_ff @(posedge clk) begin
        mbox_rd_p1   <= soc_mbox_rd;
        reg_rdata_p1 <= reg_rdata;
        soc_rdata    <= mbox_rd_p1 ? mbox_sram_rdata : reg_rdata_p1;
    end

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cptra_error_fatal     <= 1'b0;
            cptra_error_non_fatal <= 1'b0;
        end else begin
            cptra_error_fatal     <= cptra_error_fatal || err_fatal_set;
            cptra_error_non_fatal <= cptra_error_non_fatal || err_nf_set || soc_wr_drop;
        end
    end

endmodule

`default_nettype wire

// File: mbox_pkg.sv
// Shared sizes, SoC register map and boot state encoding for the mailbox controller and its testbench
`default_nettype none

package mbox_pkg;

    // Mailbox geometry
    localparam int mbox_depth  = 64;
    localparam int mbox_addr_w = 6;
    localparam int data_w      = 32;

    // SoC register port
    localparam int soc_addr_w = 8;

    // Mailbox words occupy 0x00 to 0x3F
    localparam logic [soc_addr_w-1:0] reg_mbox_base = 8'h00;
    localparam logic [soc_addr_w-1:0] reg_fuse_key  = 8'h40;
    localparam logic [soc_addr_w-1:0] reg_fuse_done = 8'h41;
    localparam logic [soc_addr_w-1:0] reg_dlen      = 8'h42;
    localparam logic [soc_addr_w-1:0] reg_execute   = 8'h43;
    localparam logic [soc_addr_w-1:0] reg_result    = 8'h44;
    localparam logic [soc_addr_w-1:0] reg_status    = 8'h45;

    // Bit positions in reg_status
    localparam int status_busy       = 0;
    localparam int status_data_avail = 1;
    localparam int status_err_nf     = 2;
    localparam int status_err_fatal  = 3;

    // Boot sequencer states
    typedef enum logic [1:0] {
        boot_fuses,
        boot_ready,
        boot_busy,
        boot_error
    } boot_state_t;

endpackage

`default_nettype wire

// File: mbox_top.sv
// Mailbox controller top level wiring sequencer, SoC decode and digest engine, with the SRAM exported
`timescale 1ns/1ps
`default_nettype none

module mbox_top import mbox_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   soc_req,
    input  logic                   soc_we,
    input  logic [soc_addr_w-1:0]  soc_addr,
    input  logic [data_w-1:0]      soc_wdata,
    output logic                   soc_rvalid,
    output logic [data_w-1:0]      soc_rdata,
    output logic                   mbox_sram_cs,
    output logic                   mbox_sram_we,
    output logic [mbox_addr_w-1:0] mbox_sram_addr,
    output logic [data_w-1:0]      mbox_sram_wdata,
    input  logic [data_w-1:0]      mbox_sram_rdata,
    output logic                   ready_for_fuses,
    output logic                   ready_for_mb_processing,
    output logic                   mailbox_data_avail,
    output logic                   cptra_error_fatal,
    output logic                   cptra_error_non_fatal
);

    logic                   fuse_key_we;
    logic                   fuse_done_we;
    logic                   execute_we;
    logic [data_w-1:0]      wdata;
    logic [6:0]             dlen;
    logic [data_w-1:0]      fuse_key;
    logic                   exec_start;
    boot_state_t            state;
    logic                   err_fatal_set;
    logic                   err_nf_set;
    logic                   eng_rd_req;
    logic [mbox_addr_w-1:0] eng_rd_addr;
    logic                   eng_rd_grant;
    logic [data_w-1:0]      eng_rd_data;
    logic [data_w-1:0]      digest;
    logic                   eng_done;

    boot_fsm boot_fsm_i (
        .clk                     (clk),
        .rst                     (rst),
        .fuse_key_we             (fuse_key_we),
        .fuse_done_we            (fuse_done_we),
        .execute_we              (execute_we),
        .wdata                   (wdata),
        .dlen                    (dlen),
        .eng_done                (eng_done),
        .fuse_key                (fuse_key),
        .exec_start              (exec_start),
        .state                   (state),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .mailbox_data_avail      (mailbox_data_avail),
        .err_fatal_set           (err_fatal_set),
        .err_nf_set              (err_nf_set)
    );

    mbox_ctrl mbox_ctrl_i (
        .clk                   (clk),
        .rst                   (rst),
        .soc_req               (soc_req),
        .soc_we                (soc_we),
        .soc_addr              (soc_addr),
        .soc_wdata             (soc_wdata),
        .soc_rvalid            (soc_rvalid),
        .soc_rdata             (soc_rdata),
        .state                 (state),
        .digest                (digest),
        .mailbox_data_avail    (mailbox_data_avail),
        .err_fatal_set         (err_fatal_set),
        .err_nf_set            (err_nf_set),
        .eng_rd_req            (eng_rd_req),
        .eng_rd_addr           (eng_rd_addr),
        .eng_rd_grant          (eng_rd_grant),
        .eng_rd_data           (eng_rd_data),
        .fuse_key_we           (fuse_key_we),
        .fuse_done_we          (fuse_done_we),
        .execute_we            (execute_we),
        .wdata                 (wdata),
        .dlen                  (dlen),
        .mbox_sram_cs          (mbox_sram_cs),
        .mbox_sram_we          (mbox_sram_we),
        .mbox_sram_addr        (mbox_sram_addr),
        .mbox_sram_wdata       (mbox_sram_wdata),
        .mbox_sram_rdata       (mbox_sram_rdata),
        .cptra_error_fatal     (cptra_error_fatal),
        .cptra_error_non_fatal (cptra_error_non_fatal)
    );

    // Digest is seeded with the obfuscation key
    digest_engine digest_engine_i (
        .clk        (clk),
        .rst        (rst),
        .exec_start (exec_start),
        .seed       (fuse_key),
        .dlen       (dlen),
        .rd_grant   (eng_rd_grant),
        .rd_data    (eng_rd_data),
        .rd_req     (eng_rd_req),
        .rd_addr    (eng_rd_addr),
        .digest     (digest),
        .done       (eng_done)
    );

endmodule

`default_nettype wire

// File: tb_mbox_assertions.sv
// Concurrent checks on read return, SRAM ownership and sticky error flags, bound into mbox_ctrl
`timescale 1ns/1ps
`default_nettype none

module tb_mbox_assertions import mbox_pkg::*; (
    input logic                   clk,
    input logic                   rst,
    input logic                   soc_req,
    input logic                   soc_we,
    input logic                   soc_rvalid,
    input logic                   soc_sram_sel,
    input logic                   eng_rd_req,
    input logic [mbox_addr_w-1:0] eng_rd_addr,
    input logic                   cptra_error_fatal,
    input logic                   cptra_error_non_fatal
);

    // Every read return traces back to a read request two cycles earlier
    rvalid_has_request: assert property (
        @(posedge clk) disable iff (rst)
        soc_rvalid |-> $past(soc_req && !soc_we, 2)
    ) else $error("soc_rvalid high without a read request two cycles before");

    // SoC takes the SRAM and the engine asks again for the same word
    sram_soc_priority: assert property (
        @(posedge clk) disable iff (rst)
        (soc_sram_sel && eng_rd_req) |=> (eng_rd_req && $stable(eng_rd_addr))
    ) else $error("engine read refused for the SoC was not retried at the same address");

    // Only reset clears the error outputs
    fatal_sticky: assert property (
        @(posedge clk) disable iff (rst)
        $past(cptra_error_fatal) |-> cptra_error_fatal
    ) else $error("cptra_error_fatal fell without reset");

    non_fatal_sticky: assert property (
        @(posedge clk) disable iff (rst)
        $past(cptra_error_non_fatal) |-> cptra_error_non_fatal
    ) else $error("cptra_error_non_fatal fell without reset");

endmodule

bind mbox_ctrl tb_mbox_assertions assertions_i (
    .clk                   (clk),
    .rst                   (rst),
    .soc_req               (soc_req),
    .soc_we                (soc_we),
    .soc_rvalid            (soc_rvalid),
    .soc_sram_sel          (soc_sram_sel),
    .eng_rd_req            (eng_rd_req),
    .eng_rd_addr           (eng_rd_addr),
    .cptra_error_fatal     (cptra_error_fatal),
    .cptra_error_non_fatal (cptra_error_non_fatal)
);

`default_nettype wire

// File: tb_mbox_top.sv
// Testbench top that boots the mailbox controller, fills the mailbox and checks digests and errors
`timescale 1ns/1ps
`default_nettype none

module tb_mbox_top import mbox_pkg::*; ();

    logic                   core_clk;
    logic                   rst;
    logic                   soc_req;
    logic                   soc_we;
    logic [soc_addr_w-1:0]  soc_addr;
    logic [data_w-1:0]      soc_wdata;
    logic                   soc_rvalid;
    logic [data_w-1:0]      soc_rdata;
    logic                   mbox_sram_cs;
    logic                   mbox_sram_we;
    logic [mbox_addr_w-1:0] mbox_sram_addr;
    logic [data_w-1:0]      mbox_sram_wdata;
    logic [data_w-1:0]      mbox_sram_rdata;
    logic                   ready_for_fuses;
    logic                   ready_for_mb_processing;
    logic                   mailbox_data_avail;
    logic                   cptra_error_fatal;
    logic                   cptra_error_non_fatal;

    // Expected mailbox contents and key as the SoC wrote them
    logic [data_w-1:0]      mbox_model [mbox_depth];
    logic [data_w-1:0]      key_model;
    logic [31:0]            lfsr_state;

    mbox_top dut_i (
        .clk                     (core_clk),
        .rst                     (rst),
        .soc_req                 (soc_req),
        .soc_we                  (soc_we),
        .soc_addr                (soc_addr),
        .soc_wdata               (soc_wdata),
        .soc_rvalid              (soc_rvalid),
        .soc_rdata               (soc_rdata),
        .mbox_sram_cs            (mbox_sram_cs),
        .mbox_sram_we            (mbox_sram_we),
        .mbox_sram_addr          (mbox_sram_addr),
        .mbox_sram_wdata         (mbox_sram_wdata),
        .mbox_sram_rdata         (mbox_sram_rdata),
        .ready_for_fuses         (ready_for_fuses),
        .ready_for_mb_processing (ready_for_mb_processing),
        .mailbox_data_avail      (mailbox_data_avail),
        .cptra_error_fatal       (cptra_error_fatal),
        .cptra_error_non_fatal   (cptra_error_non_fatal)
    );

    tb_sram_services sram_i (
        .clk   (core_clk),
        .cs    (mbox_sram_cs),
        .we    (mbox_sram_we),
        .addr  (mbox_sram_addr),
        .wdata (mbox_sram_wdata),
        .rdata (mbox_sram_rdata)
    );

    initial core_clk = 1'b0;
    always #10 core_clk = ~core_clk;

    task automatic stop_on_error();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic next_rand_word(output logic [data_w-1:0] w);
        w = '0;
        for (int b = 0; b < data_w; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[data_w-2:0], lfsr_state[0]};
        end
    endtask

    // Rotate left by one, then XOR the next word, starting from the key
    function automatic logic [data_w-1:0] fold_words(input logic [data_w-1:0] key,
                                                     input int count);
        logic [data_w-1:0] acc;
        acc = key;
        for (int i = 0; i < count; i++) begin
            acc = {acc[data_w-2:0], acc[data_w-1]} ^ mbox_model[i];
        end
        return acc;
    endfunction

    task automatic reset_dut();
        rst = 1'b1;
        repeat (16) @(posedge core_clk);
        #2;
        rst = 1'b0;
    endtask

    task automatic soc_write(input logic [soc_addr_w-1:0] addr, input logic [data_w-1:0] data);
        @(posedge core_clk);
        #2;
        soc_req   = 1'b1;
        soc_we    = 1'b1;
        soc_addr  = addr;
        soc_wdata = data;
        @(posedge core_clk);
        #2;
        soc_req = 1'b0;
        soc_we  = 1'b0;
    endtask

    task automatic soc_read(input logic [soc_addr_w-1:0] addr, output logic [data_w-1:0] data);
        int lat;
        @(posedge core_clk);
        #2;
        soc_req  = 1'b1;
        soc_we   = 1'b0;
        soc_addr = addr;
        @(posedge core_clk);
        #2;
        soc_req = 1'b0;
        lat = 1;
        @(negedge core_clk);
        while (soc_rvalid !== 1'b1) begin
            lat++;
            if (lat > 20) begin
                $display("Timeout: no soc_rvalid within 20 cycles of a read at 0x%h", addr);
                stop_on_error();
            end
            @(negedge core_clk);
        end
        check_data("soc_rvalid latency", data_w'(lat), data_w'(2));
        data = soc_rdata;
    endtask

    task automatic wait_data_avail();
        int n;
        n = 0;
        @(negedge core_clk);
        while (mailbox_data_avail !== 1'b1) begin
            n++;
            if (n > 300) begin
                $display("Timeout: mailbox_data_avail did not rise within 300 cycles");
                stop_on_error();
            end
            @(negedge core_clk);
        end
    endtask

    task automatic run_digest(input int count, input logic [data_w-1:0] key);
        logic [data_w-1:0] result;
        soc_write(reg_dlen, data_w'(count));
        soc_write(reg_execute, '0);
        wait_data_avail();
        soc_read(reg_result, result);
        check_data("reg_result", result, fold_words(key, count));
        check_bit("cptra_error_fatal", cptra_error_fatal, 1'b0);
    endtask

    task automatic test_boot_flow();
        @(negedge core_clk);
        check_bit("ready_for_fuses", ready_for_fuses, 1'b1);
        check_bit("ready_for_mb_processing", ready_for_mb_processing, 1'b0);
        check_bit("mailbox_data_avail", mailbox_data_avail, 1'b0);
        check_bit("cptra_error_fatal", cptra_error_fatal, 1'b0);
        check_bit("cptra_error_non_fatal", cptra_error_non_fatal, 1'b0);
        next_rand_word(key_model);
        soc_write(reg_fuse_key, key_model);
        soc_write(reg_fuse_done, '0);
        @(negedge core_clk);
        check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
        check_bit("ready_for_mb_processing", ready_for_mb_processing, 1'b1);
        check_bit("cptra_error_non_fatal", cptra_error_non_fatal, 1'b0);
    endtask

    task automatic test_mailbox_rw();
        logic [data_w-1:0] w;
        for (int i = 0; i < mbox_depth; i++) begin
            next_rand_word(w);
            mbox_model[i] = w;
            soc_write(reg_mbox_base + soc_addr_w'(i), w);
        end
        for (int i = 0; i < mbox_depth; i++) begin
            soc_read(reg_mbox_base + soc_addr_w'(i), w);
            check_data("soc_rdata", w, mbox_model[i]);
        end
    endtask

    task automatic test_digest_lengths();
        run_digest(0, key_model);
        run_digest(1, key_model);
        run_digest(17, key_model);
        run_digest(64, key_model);
    endtask

    task automatic test_busy_misuse();
        logic [data_w-1:0] new_word;
        logic [data_w-1:0] other_key;
        logic [data_w-1:0] got;
        next_rand_word(new_word);
        next_rand_word(other_key);
        soc_write(reg_dlen, data_w'(64));
        soc_write(reg_execute, '0);
        // SoC read steals the SRAM from the running engine
        soc_read(reg_mbox_base + soc_addr_w'(9), got);
        check_data("soc_rdata", got, mbox_model[9]);
        soc_read(reg_status, got);
        check_bit("status busy", got[status_busy], 1'b1);
        soc_write(reg_mbox_base + soc_addr_w'(5), new_word);
        @(negedge core_clk);
        check_bit("cptra_error_non_fatal", cptra_error_non_fatal, 1'b1);
        wait_data_avail();
        soc_read(reg_result, got);
        check_data("reg_result", got, fold_words(key_model, 64));
        soc_read(reg_mbox_base + soc_addr_w'(5), got);
        check_data("soc_rdata", got, mbox_model[5]);
        // Key is locked once fuses are done
        soc_write(reg_fuse_key, other_key);
        run_digest(17, key_model);
    endtask

    task automatic test_fatal_dlen();
        int n;
        reset_dut();
        @(negedge core_clk);
        check_bit("cptra_error_non_fatal", cptra_error_non_fatal, 1'b0);
        soc_write(reg_fuse_key, key_model);
        soc_write(reg_fuse_done, '0);
        // Late key write is refused and flagged
        soc_write(reg_fuse_key, ~key_model);
        @(negedge core_clk);
        check_bit("cptra_error_non_fatal", cptra_error_non_fatal, 1'b1);
        soc_write(reg_dlen, data_w'(65));
        soc_write(reg_execute, '0);
        @(negedge core_clk);
        check_bit("cptra_error_fatal", cptra_error_fatal, 1'b1);
        check_bit("ready_for_mb_processing", ready_for_mb_processing, 1'b0);
        soc_write(reg_dlen, data_w'(1));
        soc_write(reg_execute, '0);
        n = 0;
        while (n < 200) begin
            @(negedge core_clk);
            if (mailbox_data_avail !== 1'b0) begin
                $display("mailbox_data_avail rose after an execute in the error state");
                stop_on_error();
            end
            n++;
        end
    endtask

    initial begin
        lfsr_state = 32'h7251_38f3;
        rst        = 1'b1;
        soc_req    = 1'b0;
        soc_we     = 1'b0;
        soc_addr   = '0;
        soc_wdata  = '0;
        reset_dut();
        test_boot_flow();
        test_mailbox_rw();
        test_digest_lengths();
        test_busy_misuse();
        test_fatal_dlen();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_sram_services.sv
// Testbench model of the exported mailbox SRAM, answers reads one cycle after the select
`timescale 1ns/1ps
`default_nettype none

module tb_sram_services import mbox_pkg::*; (
    input  logic                   clk,
    input  logic                   cs,
    input  logic                   we,
    input  logic [mbox_addr_w-1:0] addr,
    input  logic [data_w-1:0]      wdata,
    output logic [data_w-1:0]      rdata
);

    logic [data_w-1:0] mem [mbox_depth];

    // Known contents before the SoC writes anything
    initial begin
        for (int i = 0; i < mbox_depth; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (32'(i) * 32'h0000_1001);
        end
    end

    always @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= wdata;
        end
        // Read data valid for the cycle after the select
        if (cs && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
mbox_pkg.sv
boot_fsm.sv
mbox_ctrl.sv
digest_engine.sv
mbox_top.sv
tb_sram_services.sv
tb_mbox_assertions.sv
tb_mbox_top.sv
